//--- multih.f
rtl/dmd_bus_pkg.sv
rtl/dmd_dac_pkg.sv
rtl/axil_reg_fsm.sv
rtl/reset_stretch.sv
rtl/dac_channel.sv
rtl/multih_top.sv
test/multih_chk.sv
test/multih_tb.sv

//--- rtl/axil_reg_fsm.sv
//**********************************************************
// AXI4-Lite register slave
// Version word, soft reset trigger and DAC control word
// behind a three state handshake FSM
//**********************************************************
`default_nettype none

module axil_reg_fsm
  import dmd_bus_pkg::*;
  import dmd_dac_pkg::*;
(
  input  wire logic      ck933_i,
  input  wire logic      rs_i,
  input  wire logic      core_rst_i,
  input  wire axil_req_t axil_req_i,
  output axil_rsp_t      axil_rsp_o,
  output logic           soft_rst_o,
  output dac_ctrl_u      dac_ctrl_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE_RESP,
    ST_READ_RESP
  } state_t;

  state_t            state_q;
  logic              idle;
  logic              wr_present;
  logic              wr_go;
  logic              rd_go;
  logic              ctrl_wr;
  logic [1:0]        wr_resp;
  logic [1:0]        rd_resp;
  logic [DATA_W-1:0] rd_data;
  logic [1:0]        bresp_q;
  logic [1:0]        rresp_q;
  logic [DATA_W-1:0] rdata_q;
  dac_ctrl_u         ctrl_q;

  //**********************************************************
  // Handshake decode
  //**********************************************************
  assign idle       = (state_q == ST_IDLE);
  assign wr_present = axil_req_i.awvalid || axil_req_i.wvalid;  // Writes win over reads
  assign wr_go      = idle && axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_go      = idle && axil_req_i.arvalid && !wr_present;

  assign soft_rst_o = wr_go && (axil_req_i.awaddr == ADDR_RESET);
  assign ctrl_wr    = wr_go && (axil_req_i.awaddr == ADDR_DAC_CTRL);

  // Write address check
  always_comb begin
    case (axil_req_i.awaddr)
      ADDR_RESET,
      ADDR_DAC_CTRL: wr_resp = RESP_OKAY;
      default:       wr_resp = RESP_SLVERR;
    endcase
  end

  // Read mux where unmapped space reads as zero
  always_comb begin
    case (axil_req_i.araddr)
      ADDR_VERSION: begin
        rd_data = VER_NUMBER;
        rd_resp = RESP_OKAY;
      end
      ADDR_DAC_CTRL: begin
        rd_data = ctrl_q.raw;
        rd_resp = RESP_OKAY;
      end
      default: begin
        rd_data = '0;
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  //**********************************************************
  // State machine
  //**********************************************************
  always_ff @(posedge ck933_i or posedge rs_i) begin
    if (rs_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (wr_go) state_q <= ST_WRITE_RESP;
          else if (rd_go) state_q <= ST_READ_RESP;
        end
        ST_WRITE_RESP: if (axil_req_i.bready) state_q <= ST_IDLE;  // Hold until taken
        ST_READ_RESP:  if (axil_req_i.rready) state_q <= ST_IDLE;
        default:       state_q <= ST_IDLE;
      endcase
    end
  end

  // Response payload captured at accept
  always_ff @(posedge ck933_i) begin
    if (wr_go) bresp_q <= wr_resp;
    if (rd_go) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  // DAC control word with byte strobes
  always_ff @(posedge ck933_i or posedge rs_i) begin
    if (rs_i) begin
      ctrl_q.raw <= '0;
    end else if (core_rst_i) begin
      ctrl_q.raw <= '0;
    end else if (ctrl_wr) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (axil_req_i.wstrb[b]) ctrl_q.raw[8*b +: 8] <= axil_req_i.wdata[8*b +: 8];
      end
    end
  end

  assign dac_ctrl_o = ctrl_q;

  assign axil_rsp_o.awready = idle;
  assign axil_rsp_o.wready  = idle;
  assign axil_rsp_o.arready = idle && !wr_present;
  assign axil_rsp_o.bvalid  = (state_q == ST_WRITE_RESP);
  assign axil_rsp_o.bresp   = bresp_q;
  assign axil_rsp_o.rvalid  = (state_q == ST_READ_RESP);
  assign axil_rsp_o.rdata   = rdata_q;
  assign axil_rsp_o.rresp   = rresp_q;

endmodule

`default_nettype wire

//--- rtl/dac_channel.sv
//**********************************************************
// One DAC output channel
// Source select, offset binary formatting and the
// sync enabled output register
//**********************************************************
`default_nettype none

module dac_channel
  import dmd_dac_pkg::*;
(
  input  wire logic             ck933_i,
  input  wire logic             rs_i,
  input  wire logic             core_rst_i,
  input  wire logic [SEL_W-1:0] sel_i,
  input  wire dac_sample_t      trellis_i,
  input  wire logic [DAC_W-1:0] ext_data_i,
  output logic      [DAC_W-1:0] dac_d_o
);

  logic             use_trellis;
  dac_sample_t      src;
  dac_sample_t      s1_q;
  logic [DAC_W-1:0] fmt;
  logic [DAC_W-1:0] dac_q;

  always_comb begin
    case (sel_i)
      DAC_SEL_TRELLIS_I,
      DAC_SEL_TRELLIS_Q,
      DAC_SEL_TRELLIS_PHERR,
      DAC_SEL_TRELLIS_INDEX: use_trellis = 1'b1;
      default:               use_trellis = 1'b0;
    endcase
  end

  // External word always counts as synced
  assign src = use_trellis ? trellis_i :
               '{sync: 1'b1, data: {{(SAMPLE_W-DAC_W){1'b0}}, ext_data_i}};

  // Upper bits from two's complement to offset binary
  assign fmt = {~s1_q.data[SAMPLE_W-1], s1_q.data[SAMPLE_W-2 -: DAC_W-1]};

  always_ff @(posedge ck933_i or posedge rs_i) begin
    if (rs_i) begin
      s1_q  <= '0;
      dac_q <= '0;
    end else if (core_rst_i) begin
      s1_q  <= '0;
      dac_q <= '0;
    end else begin
      s1_q <= src;                   // Every clock
      if (s1_q.sync) dac_q <= fmt;   // Only on sync
    end
  end

  assign dac_d_o = dac_q;

endmodule

`default_nettype wire

//--- rtl/dmd_bus_pkg.sv
//**********************************************************
// Register bus definitions for the demodulator core
// AXI4-Lite request and response structs, register map,
// version word and response codes
//**********************************************************
`default_nettype none

package dmd_bus_pkg;

  // Bus geometry
  localparam int ADDR_W = 12;
  localparam int DATA_W = 16;
  localparam int STRB_W = DATA_W / 8;

  //**********************************************************
  // Register map
  //**********************************************************
  localparam logic [ADDR_W-1:0] ADDR_VERSION  = 12'h000;  // Read only
  localparam logic [ADDR_W-1:0] ADDR_RESET    = 12'h004;  // Write triggers soft reset
  localparam logic [ADDR_W-1:0] ADDR_DAC_CTRL = 12'h008;  // DAC select word

  localparam logic [DATA_W-1:0] VER_NUMBER = 16'h0079;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Master driven side
  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axil_req_t;

  // Slave driven side
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- rtl/dmd_dac_pkg.sv
//**********************************************************
// DAC output path definitions
// Sample struct, select codes, control word union,
// datapath widths and core reset length
//**********************************************************
`default_nettype none

package dmd_dac_pkg;

  localparam int SAMPLE_W = 18;  // Trellis sample
  localparam int DAC_W    = 14;  // DAC converter word
  localparam int SEL_W    = 4;
  localparam int CTRL_W   = 4 * SEL_W;

  // Core reset length in clocks
  localparam int RESET_STRETCH = 6;
  localparam int STRETCH_CNT_W = $clog2(RESET_STRETCH + 1);

  //**********************************************************
  // Trellis select codes
  //**********************************************************
  // Any other code picks the external word
  localparam logic [SEL_W-1:0] DAC_SEL_TRELLIS_I     = 4'd8;
  localparam logic [SEL_W-1:0] DAC_SEL_TRELLIS_Q     = 4'd9;
  localparam logic [SEL_W-1:0] DAC_SEL_TRELLIS_PHERR = 4'd10;
  localparam logic [SEL_W-1:0] DAC_SEL_TRELLIS_INDEX = 4'd11;

  // Trellis sample with its strobe
  typedef struct packed {
    logic                sync;
    logic [SAMPLE_W-1:0] data;
  } dac_sample_t;

  // Select fields with dac0 in the low nibble
  typedef struct packed {
    logic [SEL_W-1:0] spare;
    logic [SEL_W-1:0] dac2_sel;
    logic [SEL_W-1:0] dac1_sel;
    logic [SEL_W-1:0] dac0_sel;
  } dac_sel_fields_t;

  // Written as a bus word, read as fields by the channels
  typedef union packed {
    logic [CTRL_W-1:0] raw;
    dac_sel_fields_t   fields;
  } dac_ctrl_u;

endpackage

`default_nettype wire

//--- rtl/multih_top.sv
//**********************************************************
// Demodulator register core and DAC output path
// AXI4-Lite slave, core reset timer and three DAC channels
//**********************************************************
`default_nettype none

module multih_top
  import dmd_bus_pkg::*;
  import dmd_dac_pkg::*;
(
  input  wire logic                  ck933_i,
  input  wire logic                  rs_i,
  input  wire axil_req_t             axil_req_i,
  output axil_rsp_t                  axil_rsp_o,
  input  wire dac_sample_t [2:0]     trellis_i,
  input  wire logic [2:0][DAC_W-1:0] ext_data_i,
  output logic      [2:0][DAC_W-1:0] dac_d_o,
  output logic                       dac_rst_o
);

  logic      soft_rst;
  logic      core_rst;
  dac_ctrl_u dac_ctrl;

  //**********************************************************
  // Register slave and reset timer
  //**********************************************************
  axil_reg_fsm u_regs (
    .ck933_i    (ck933_i),
    .rs_i       (rs_i),
    .core_rst_i (core_rst),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .soft_rst_o (soft_rst),
    .dac_ctrl_o (dac_ctrl)
  );

  reset_stretch u_rst_stretch (
    .ck933_i    (ck933_i),
    .rs_i       (rs_i),
    .soft_rst_i (soft_rst),
    .core_rst_o (core_rst)
  );

  assign dac_rst_o = core_rst;  // Converter reset follows the core

  //**********************************************************
  // DAC channels
  //**********************************************************
  dac_channel u_dac0 (
    .ck933_i    (ck933_i),
    .rs_i       (rs_i),
    .core_rst_i (core_rst),
    .sel_i      (dac_ctrl.fields.dac0_sel),
    .trellis_i  (trellis_i[0]),
    .ext_data_i (ext_data_i[0]),
    .dac_d_o    (dac_d_o[0])
  );

  dac_channel u_dac1 (
    .ck933_i    (ck933_i),
    .rs_i       (rs_i),
    .core_rst_i (core_rst),
    .sel_i      (dac_ctrl.fields.dac1_sel),
    .trellis_i  (trellis_i[1]),
    .ext_data_i (ext_data_i[1]),
    .dac_d_o    (dac_d_o[1])
  );

  dac_channel u_dac2 (
    .ck933_i    (ck933_i),
    .rs_i       (rs_i),
    .core_rst_i (core_rst),
    .sel_i      (dac_ctrl.fields.dac2_sel),
    .trellis_i  (trellis_i[2]),
    .ext_data_i (ext_data_i[2]),
    .dac_d_o    (dac_d_o[2])
  );

endmodule

`default_nettype wire

//--- rtl/reset_stretch.sv
//**********************************************************
// Soft reset stretcher
// Turns a one clock request into a fixed length core reset
//**********************************************************
`default_nettype none

module reset_stretch
  import dmd_dac_pkg::*;
(
  input  wire logic ck933_i,
  input  wire logic rs_i,
  input  wire logic soft_rst_i,
  output logic      core_rst_o
);

  logic [STRETCH_CNT_W-1:0] cnt_q;

  // A new request during the stretch restarts the count
  always_ff @(posedge ck933_i or posedge rs_i) begin
    if (rs_i) begin
      cnt_q <= '0;
    end else if (soft_rst_i) begin
      cnt_q <= STRETCH_CNT_W'(RESET_STRETCH);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign core_rst_o = (cnt_q != '0);  // High while counting down

endmodule

`default_nettype wire

//--- test/multih_chk.sv
//**********************************************************
// Bound assertions for the register core
// AXI4-Lite response handshakes and core reset length
//**********************************************************
`default_nettype none

module multih_chk
  import dmd_bus_pkg::*;
  import dmd_dac_pkg::*;
(
  input wire logic      ck933_i,
  input wire logic      rs_i,
  input wire axil_req_t axil_req_i,
  input wire axil_rsp_t axil_rsp_i,
  input wire logic      soft_rst_i,
  input wire logic      dac_rst_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // Write response held until taken
  a_bvalid_hold: assert property (@(posedge ck933_i) disable iff (rs_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid)
    else begin
      $error("bvalid dropped before bready");
      fail_cnt++;
    end

  a_rvalid_hold: assert property (@(posedge ck933_i) disable iff (rs_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
    else begin
      $error("rvalid or rdata changed before rready");
      fail_cnt++;
    end

  a_no_aw_in_resp: assert property (@(posedge ck933_i) disable iff (rs_i)
    axil_rsp_i.bvalid |-> !axil_rsp_i.awready)
    else begin
      $error("awready high with a pending write response");
      fail_cnt++;
    end

  // Stretched reset of exact length
  a_rst_len: assert property (@(posedge ck933_i) disable iff (rs_i)
    soft_rst_i |=> dac_rst_i [*RESET_STRETCH] ##1 !dac_rst_i)
    else begin
      $error("dac_rst_o length differs from the stretch");
      fail_cnt++;
    end

endmodule

bind multih_top multih_chk u_chk (
  .ck933_i    (ck933_i),
  .rs_i       (rs_i),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o),
  .soft_rst_i (soft_rst),
  .dac_rst_i  (dac_rst_o)
);

`default_nettype wire

//--- test/multih_tb.sv
//**********************************************************
// Testbench for the demodulator register core
// Clock and reset, AXI4-Lite driver tasks, random DAC
// stimulus, reference model of the channels and checks
//**********************************************************
`default_nettype none

module multih_tb
  import dmd_bus_pkg::*;
  import dmd_dac_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 4000;  // About twice the full run

  logic                  ck933;
  logic                  rs;
  axil_req_t             req;
  axil_rsp_t             rsp;
  dac_sample_t [2:0]     trellis;
  logic [2:0][DAC_W-1:0] ext_data;
  logic [2:0][DAC_W-1:0] dac_d;
  logic                  dac_rst;
  integer                seed;
  int                    cycles;

  // Reference model state
  dac_sample_t       m_s1 [3];
  logic [DAC_W-1:0]  m_dac [3];
  logic [DATA_W-1:0] m_ctrl;
  int                m_cnt;
  logic              pend_ctrl_wr;
  logic [DATA_W-1:0] pend_ctrl_data;
  logic              pend_rst;
  logic              zero_due;        // Core reset just ended

  multih_top DUT (
    .ck933_i    (ck933),
    .rs_i       (rs),
    .axil_req_i (req),
    .axil_rsp_o (rsp),
    .trellis_i  (trellis),
    .ext_data_i (ext_data),
    .dac_d_o    (dac_d),
    .dac_rst_o  (dac_rst)
  );

  always #10 ck933 = ~ck933;

  always @(posedge ck933) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout, the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("ERR @%0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // New random trellis samples and external words
  task automatic drive_samples();
    logic [31:0] r;
    for (int ch = 0; ch < 3; ch++) begin
      r = $random(seed);
      trellis[ch].data = r[SAMPLE_W-1:0];
      trellis[ch].sync = r[31];
      r = $random(seed);
      ext_data[ch] = r[DAC_W-1:0];
    end
  endtask

  //**********************************************************
  // Channel and reset model stepped at the falling edge
  //**********************************************************
  task automatic model_step();
    logic             core;
    logic [SEL_W-1:0] sel;
    logic [DAC_W-1:0] up;
    for (int ch = 0; ch < 3; ch++) begin
      if (zero_due) check_eq(dac_d[ch], 0, "dac_d_o after core reset");
      check_eq(dac_d[ch], m_dac[ch], "dac_d_o vs model");
    end
    check_eq(dac_rst, m_cnt != 0, "dac_rst_o");
    core = (m_cnt != 0);
    for (int ch = 0; ch < 3; ch++) begin
      sel = m_ctrl[SEL_W*ch +: SEL_W];  // dac0 in the low nibble
      if (core) begin
        m_s1[ch]  = '0;
        m_dac[ch] = '0;
      end else begin
        up = m_s1[ch].data[SAMPLE_W-1 -: DAC_W];
        if (m_s1[ch].sync) m_dac[ch] = {~up[DAC_W-1], up[DAC_W-2:0]};
        if (sel inside {DAC_SEL_TRELLIS_I, DAC_SEL_TRELLIS_Q,
                        DAC_SEL_TRELLIS_PHERR, DAC_SEL_TRELLIS_INDEX}) begin
          m_s1[ch] = trellis[ch];
        end else begin
          m_s1[ch].sync = 1'b1;
          m_s1[ch].data = {{(SAMPLE_W-DAC_W){1'b0}}, ext_data[ch]};
        end
      end
    end
    if (core) m_ctrl = '0;
    else if (pend_ctrl_wr) m_ctrl = pend_ctrl_data;
    if (pend_rst) m_cnt = RESET_STRETCH;
    else if (m_cnt != 0) m_cnt--;
    zero_due     = core && (m_cnt == 0);
    pend_ctrl_wr = 1'b0;
    pend_rst     = 1'b0;
  endtask

  task automatic end_cycle();
    model_step();
    @(posedge ck933);
    #2;
    drive_samples();
  endtask

  task automatic idle_cycle();
    @(negedge ck933);
    end_cycle();
  endtask

  //**********************************************************
  // AXI4-Lite master tasks
  //**********************************************************
  task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
    logic done;
    int   delay;
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = '1;
    done = 1'b0;
    while (!done) begin
      @(negedge ck933);
      done = rsp.awready && rsp.wready;
      if (done && addr == ADDR_DAC_CTRL) begin
        pend_ctrl_wr   = 1'b1;
        pend_ctrl_data = data;
      end
      if (done && addr == ADDR_RESET) pend_rst = 1'b1;
      end_cycle();
    end
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    delay = $random(seed) & 3;
    repeat (delay) idle_cycle();  // bready held low
    req.bready = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge ck933);
      done = rsp.bvalid;
      resp = rsp.bresp;
      end_cycle();
    end
    req.bready = 1'b0;
    @(negedge ck933);
    check_eq(rsp.bvalid, 0, "bvalid after write response taken");
    end_cycle();
  endtask

  task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic [1:0] resp);
    logic done;
    int   delay;
    req.arvalid = 1'b1;
    req.araddr  = addr;
    done = 1'b0;
    while (!done) begin
      @(negedge ck933);
      done = rsp.arready;
      end_cycle();
    end
    req.arvalid = 1'b0;
    delay = $random(seed) & 3;
    repeat (delay) idle_cycle();  // rready held low
    req.rready = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(negedge ck933);
      done = rsp.rvalid;
      data = rsp.rdata;
      resp = rsp.rresp;
      end_cycle();
    end
    req.rready = 1'b0;
    @(negedge ck933);
    check_eq(rsp.rvalid, 0, "rvalid after read response taken");
    end_cycle();
  endtask

  //**********************************************************
  // Test sequence
  //**********************************************************
  initial begin
    logic [DATA_W-1:0] wd;
    logic [DATA_W-1:0] rd;
    logic [1:0]        resp;
    logic [31:0]       r;
    seed     = 85129;
    cycles   = 0;
    ck933    = 1'b0;
    rs       = 1'b1;
    req      = '0;
    trellis  = '0;
    ext_data = '0;
    for (int ch = 0; ch < 3; ch++) begin
      m_s1[ch]  = '0;
      m_dac[ch] = '0;
    end
    m_ctrl       = '0;
    m_cnt        = 0;
    pend_ctrl_wr = 1'b0;
    pend_rst     = 1'b0;
    zero_due     = 1'b0;
    repeat (16) @(posedge ck933);
    #2;
    rs = 1'b0;

    // Idle handshake levels and version word
    @(negedge ck933);
    check_eq({rsp.awready, rsp.wready, rsp.arready, rsp.bvalid, rsp.rvalid},
             5'b11100, "handshake outputs after reset");
    end_cycle();
    axil_read(ADDR_VERSION, rd, resp);
    check_eq(rd, VER_NUMBER, "version word");
    check_eq(resp, RESP_OKAY, "version read response");
    check_eq(dac_rst, 0, "dac_rst_o after reset");

    // Control word read back
    repeat (20) begin
      wd = $random(seed);
      axil_write(ADDR_DAC_CTRL, wd, resp);
      check_eq(resp, RESP_OKAY, "control write response");
      axil_read(ADDR_DAC_CTRL, rd, resp);
      check_eq(rd, wd, "control word read back");
      check_eq(resp, RESP_OKAY, "control read response");
    end
    axil_read(12'h0fc, rd, resp);
    check_eq(rd, 0, "unmapped read data");
    check_eq(resp, RESP_SLVERR, "unmapped read response");
    axil_write(12'h0f0, 16'h1234, resp);
    check_eq(resp, RESP_SLVERR, "unmapped write response");
    axil_write(ADDR_VERSION, 16'hbeef, resp);
    check_eq(resp, RESP_SLVERR, "version write response");

    // Streaming with random selects where about half are trellis codes
    repeat (20) begin
      r  = $random(seed);
      wd = r[31:16];
      for (int ch = 0; ch < 3; ch++) begin
        r = $random(seed);
        wd[SEL_W*ch +: SEL_W] = r[4] ? {2'b10, r[1:0]} : r[3:0];
      end
      axil_write(ADDR_DAC_CTRL, wd, resp);
      check_eq(resp, RESP_OKAY, "select write response");
      repeat (50) idle_cycle();
    end

    // Soft reset
    axil_write(ADDR_RESET, 16'h0001, resp);
    check_eq(resp, RESP_OKAY, "soft reset write response");
    while (m_cnt != 0) idle_cycle();
    idle_cycle();
    axil_read(ADDR_DAC_CTRL, rd, resp);
    check_eq(rd, 0, "control word after soft reset");
    repeat (10) idle_cycle();

    if (DUT.u_chk.fail_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "Bound assertions reported %0d failures", DUT.u_chk.fail_cnt);
    end
  end

endmodule

`default_nettype wire
